// ==== common/rob_pkg.sv ====
`default_nettype none

package rob_pkg;

    // tag index width, covers rob_depth up to 8 rows
    localparam int rob_idx_w = 3;

    typedef logic [rob_idx_w-1:0] rob_idx_t;
    typedef logic [3:0]           reg_idx_t;
    typedef logic [15:0]          word_t;

    // add/sub/xor run on an alu, mul on the multiplier
    typedef enum logic [1:0] {
        op_add = 2'd0,
        op_sub = 2'd1,
        op_xor = 2'd2,
        op_mul = 2'd3
    } rob_op_e;

    typedef struct packed {
        logic     valid;
        rob_op_e  op;
        reg_idx_t dest;
        word_t    opa;
        word_t    opb;
    } uop_t;

    // slot 0 is the older micro-op
    typedef struct packed {
        uop_t [1:0] slot;
    } uop_pair_t;

    // row index plus slot within the row
    typedef struct packed {
        rob_idx_t index;
        logic     slot;
    } rob_tag_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        rob_op_e  op;
        word_t    opa;
        word_t    opb;
    } issue_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        word_t    result;
    } finish_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t dest;
        word_t    result;
    } rob_slot_t;

    typedef struct packed {
        rob_slot_t [1:0] slot;
    } commit_row_t;

endpackage

`default_nettype wire

// ==== hw/dispatch_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module dispatch_stage #(
    parameter int rob_depth = 8
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          flush,
    input  wire  rob_pkg::uop_pair_t     in_pair,
    input  wire                          in_valid,
    output logic                         in_ready,
    output rob_pkg::uop_pair_t           alloc_pair,
    output logic                         alloc_valid,
    input  wire                          alloc_ready,
    input  wire  [$clog2(rob_depth)-1:0] alloc_index,
    output rob_pkg::issue_t              alu0_issue,
    output rob_pkg::issue_t              alu1_issue,
    output rob_pkg::issue_t              mdu_issue
);
    import rob_pkg::*;

    logic                         enabled;
    logic                         mul_pending;
    logic [$clog2(rob_depth)-1:0] pend_index;
    logic [1:0]                   is_mul;
    logic                         any_valid;
    logic                         split;
    logic                         alloc_fire;
    rob_tag_t [1:0]               tag;

    function automatic issue_t make_issue(uop_t uop, rob_tag_t tag_in);
        issue_t iss;
        iss.valid = 1'b1;
        iss.tag   = tag_in;
        iss.op    = uop.op;
        iss.opa   = uop.opa;
        iss.opb   = uop.opb;
        return iss;
    endfunction

    assign is_mul[0] = in_pair.slot[0].valid && in_pair.slot[0].op == op_mul;
    assign is_mul[1] = in_pair.slot[1].valid && in_pair.slot[1].op == op_mul;
    assign any_valid = in_pair.slot[0].valid || in_pair.slot[1].valid;
    // multiplier takes one op per cycle, two muls need two cycles
    assign split     = &is_mul;

    assign alloc_pair  = in_pair;
    assign alloc_valid = enabled && !flush && !mul_pending && in_valid && any_valid;
    assign alloc_fire  = alloc_valid && alloc_ready;

    // empty pairs pass without a rob row
    // split pair is acked on its second cycle
    assign in_ready = enabled && !flush &&
                      (mul_pending || !any_valid || (alloc_ready && !split));

    always_comb begin
        tag[0].index = rob_idx_t'(alloc_index);
        tag[0].slot  = 1'b0;
        // rob tail has moved on by the second mul issue
        tag[1].index = rob_idx_t'(mul_pending ? pend_index : alloc_index);
        tag[1].slot  = 1'b1;
    end

    always_comb begin
        alu0_issue = '0;
        alu1_issue = '0;
        mdu_issue  = '0;
        if (mul_pending) begin
            if (in_valid && in_ready) begin
                mdu_issue = make_issue(in_pair.slot[1], tag[1]);
            end
        end else if (alloc_fire) begin
            if (is_mul[0]) begin
                mdu_issue = make_issue(in_pair.slot[0], tag[0]);
            end else if (in_pair.slot[0].valid) begin
                alu0_issue = make_issue(in_pair.slot[0], tag[0]);
            end
            if (in_pair.slot[1].valid && !is_mul[1]) begin
                alu1_issue = make_issue(in_pair.slot[1], tag[1]);
            end else if (is_mul[1] && !split) begin
                mdu_issue = make_issue(in_pair.slot[1], tag[1]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            enabled     <= 1'b0;
            mul_pending <= 1'b0;
        end else begin
            enabled <= 1'b1;
            if (flush) begin
                mul_pending <= 1'b0;
            end else if (mul_pending && in_valid) begin
                mul_pending <= 1'b0;
            end else if (alloc_fire && split) begin
                mul_pending <= 1'b1;
            end
        end
    end

    // row of the first mul, reused for the second
    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            pend_index <= alloc_index;
        end
    end

    // each in-flight micro-op owns a unique tag
    assert property (@(posedge clk) disable iff (rst)
        !(alu0_issue.valid && alu1_issue.valid && alu0_issue.tag == alu1_issue.tag) &&
        !(alu0_issue.valid && mdu_issue.valid && alu0_issue.tag == mdu_issue.tag) &&
        !(alu1_issue.valid && mdu_issue.valid && alu1_issue.tag == mdu_issue.tag))
        else $error("dispatch: duplicate tag issued in one cycle");

endmodule

`default_nettype wire

// ==== rob/reorder_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

module reorder_buffer #(
    parameter int rob_depth = 8
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          flush,
    input  wire  rob_pkg::uop_pair_t     alloc_pair,
    input  wire                          alloc_valid,
    output logic                         alloc_ready,
    output logic [$clog2(rob_depth)-1:0] alloc_index,
    input  wire  rob_pkg::finish_t       alu0_finish,
    input  wire  rob_pkg::finish_t       alu1_finish,
    input  wire  rob_pkg::finish_t       mdu_finish,
    output rob_pkg::commit_row_t         row,
    output logic                         row_valid,
    input  wire                          row_ready
);
    import rob_pkg::*;

    localparam int idx_w = $clog2(rob_depth);

    // extra msb on the pointers tells full from empty
    logic [idx_w:0]   head;
    logic [idx_w:0]   tail;
    logic [idx_w:0]   count;
    logic [idx_w-1:0] head_idx;
    logic [idx_w-1:0] tail_idx;
    logic             full;
    logic             empty;
    logic             alloc_fire;
    logic             row_fire;
    logic [1:0]       head_wait;
    finish_t          fin [3];

    // one array set per slot of a row
    logic     ent_valid  [2][rob_depth];
    logic     ent_busy   [2][rob_depth];
    reg_idx_t ent_dest   [2][rob_depth];
    word_t    ent_result [2][rob_depth];

    assign head_idx = head[idx_w-1:0];
    assign tail_idx = tail[idx_w-1:0];
    assign count    = tail - head;
    assign empty    = head == tail;
    assign full     = head[idx_w] != tail[idx_w] && head_idx == tail_idx;

    assign alloc_ready = !full;
    assign alloc_index = tail_idx;
    assign alloc_fire  = alloc_valid && alloc_ready && !flush;

    assign fin[0] = alu0_finish;
    assign fin[1] = alu1_finish;
    assign fin[2] = mdu_finish;

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            row.slot[s].valid  = ent_valid[s][head_idx];
            row.slot[s].dest   = ent_dest[s][head_idx];
            row.slot[s].result = ent_result[s][head_idx];
            head_wait[s]       = ent_valid[s][head_idx] && ent_busy[s][head_idx];
        end
    end

    // head row ready once no valid slot is still executing
    assign row_valid = !empty && head_wait == 2'b00;
    assign row_fire  = row_valid && row_ready;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (row_fire) begin
                head <= head + 1'b1;
            end
            if (alloc_fire) begin
                tail <= tail + 1'b1;
            end
        end
    end

    // new row lands at the tail with every valid slot busy
    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            for (int s = 0; s < 2; s++) begin
                ent_valid[s][tail_idx] <= alloc_pair.slot[s].valid;
                ent_busy[s][tail_idx]  <= alloc_pair.slot[s].valid;
                ent_dest[s][tail_idx]  <= alloc_pair.slot[s].dest;
            end
        end
        // completions arrive out of order and are matched by tag
        for (int f = 0; f < 3; f++) begin
            if (fin[f].valid) begin
                ent_busy[fin[f].tag.slot][fin[f].tag.index[idx_w-1:0]]   <= 1'b0;
                ent_result[fin[f].tag.slot][fin[f].tag.index[idx_w-1:0]] <= fin[f].result;
            end
        end
    end

    // tag lies inside the occupied window and still waits for its result
    function automatic logic slot_live(rob_tag_t tag);
        logic [idx_w-1:0] offset;
        offset = tag.index[idx_w-1:0] - head_idx;
        return {1'b0, offset} < count &&
               ent_valid[tag.slot][tag.index[idx_w-1:0]] &&
               ent_busy[tag.slot][tag.index[idx_w-1:0]];
    endfunction

    // occupancy stays within the depth when no row is written while full
    assert property (@(posedge clk) disable iff (rst)
        count <= (idx_w + 1)'(rob_depth))
        else $error("rob: allocation while full");

    for (genvar f = 0; f < 3; f++) begin : g_fin_chk
        assert property (@(posedge clk) disable iff (rst)
            fin[f].valid |-> slot_live(fin[f].tag))
            else $error("rob: finish to an empty or idle slot");
    end

endmodule

`default_nettype wire

// ==== hw/exec_pipe.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_pipe #(
    parameter int latency = 1
) (
    input  wire              clk,
    input  wire              rst,
    input  wire              flush,
    input  wire  rob_pkg::issue_t  issue,
    output rob_pkg::finish_t finish
);
    import rob_pkg::*;

    // the multi-cycle pipe is the multiplier
    localparam bit is_mdu = latency > 1;

    word_t                  result;
    logic [latency-1:0]     st_valid;
    rob_tag_t [latency-1:0] st_tag;
    word_t [latency-1:0]    st_result;

    // low 16 bits of a op b
    always_comb begin
        case (issue.op)
            op_add:  result = issue.opa + issue.opb;
            op_sub:  result = issue.opa - issue.opb;
            op_xor:  result = issue.opa ^ issue.opb;
            op_mul:  result = issue.opa * issue.opb;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            st_valid <= '0;
        end else begin
            for (int i = latency - 1; i > 0; i--) begin
                st_valid[i] <= st_valid[i-1];
            end
            st_valid[0] <= issue.valid;
        end
    end

    // tag and result just follow the valid bit
    always_ff @(posedge clk) begin
        for (int i = latency - 1; i > 0; i--) begin
            st_tag[i]    <= st_tag[i-1];
            st_result[i] <= st_result[i-1];
        end
        st_tag[0]    <= issue.tag;
        st_result[0] <= result;
    end

    always_comb begin
        finish.valid  = st_valid[latency-1];
        finish.tag    = st_tag[latency-1];
        finish.result = st_result[latency-1];
    end

    // steering in dispatch must match the unit
    assert property (@(posedge clk) disable iff (rst)
        issue.valid |-> (issue.op == op_mul) == is_mdu)
        else $error("exec_pipe: opcode sent to the wrong unit");

endmodule

`default_nettype wire

// ==== hw/commit_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module commit_stage (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         flush,
    input  wire  rob_pkg::commit_row_t  row,
    input  wire                         row_valid,
    output logic                        row_ready,
    output logic                        retire_valid,
    input  wire                         retire_ready,
    output rob_pkg::reg_idx_t           retire_dest,
    output rob_pkg::word_t              retire_value
);
    import rob_pkg::*;

    commit_row_t held;
    logic        held_valid;
    // slot being retired, 0 then 1
    logic        ptr;
    logic        last;
    logic        retire_fire;
    rob_slot_t   cur;

    assign cur          = held.slot[ptr];
    assign retire_valid = held_valid;
    assign retire_dest  = cur.dest;
    assign retire_value = cur.result;
    assign retire_fire  = retire_valid && retire_ready;

    // nothing valid left behind the current slot
    assign last = ptr || !held.slot[1].valid;

    // refill when empty or on the last retirement of the row
    assign row_ready = !held_valid || (retire_fire && last);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            held_valid <= 1'b0;
            ptr        <= 1'b0;
        end else if (row_valid && row_ready) begin
            held_valid <= 1'b1;
            // skip an invalid slot 0
            ptr        <= !row.slot[0].valid;
        end else if (retire_fire) begin
            if (last) begin
                held_valid <= 1'b0;
            end else begin
                ptr <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (row_valid && row_ready) begin
            held <= row;
        end
    end

    // stalled retirement keeps its data
    assert property (@(posedge clk) disable iff (rst || flush)
        retire_valid && !retire_ready |=>
            retire_valid && $stable(retire_dest) && $stable(retire_value))
        else $error("commit: retire data changed while stalled");

endmodule

`default_nettype wire

// ==== hw/rob_core_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module rob_core_top #(
    parameter int rob_depth = 8
) (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      flush,
    input  wire  rob_pkg::uop_pair_t in_pair,
    input  wire                      in_valid,
    output logic                     in_ready,
    output logic                     retire_valid,
    input  wire                      retire_ready,
    output rob_pkg::reg_idx_t        retire_dest,
    output rob_pkg::word_t           retire_value
);
    import rob_pkg::*;

    uop_pair_t                    alloc_pair;
    logic                         alloc_valid;
    logic                         alloc_ready;
    logic [$clog2(rob_depth)-1:0] alloc_index;
    issue_t                       alu0_issue;
    issue_t                       alu1_issue;
    issue_t                       mdu_issue;
    finish_t                      alu0_finish;
    finish_t                      alu1_finish;
    finish_t                      mdu_finish;
    commit_row_t                  row;
    logic                         row_valid;
    logic                         row_ready;

    dispatch_stage #(
        .rob_depth (rob_depth)
    ) dispatch_stage_inst (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .in_pair     (in_pair),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .alloc_pair  (alloc_pair),
        .alloc_valid (alloc_valid),
        .alloc_ready (alloc_ready),
        .alloc_index (alloc_index),
        .alu0_issue  (alu0_issue),
        .alu1_issue  (alu1_issue),
        .mdu_issue   (mdu_issue)
    );

    reorder_buffer #(
        .rob_depth (rob_depth)
    ) reorder_buffer_inst (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .alloc_pair  (alloc_pair),
        .alloc_valid (alloc_valid),
        .alloc_ready (alloc_ready),
        .alloc_index (alloc_index),
        .alu0_finish (alu0_finish),
        .alu1_finish (alu1_finish),
        .mdu_finish  (mdu_finish),
        .row         (row),
        .row_valid   (row_valid),
        .row_ready   (row_ready)
    );

    // single-cycle alus
    exec_pipe #(.latency(1)) alu0_inst (
        .clk    (clk),
        .rst    (rst),
        .flush  (flush),
        .issue  (alu0_issue),
        .finish (alu0_finish)
    );

    exec_pipe #(.latency(1)) alu1_inst (
        .clk    (clk),
        .rst    (rst),
        .flush  (flush),
        .issue  (alu1_issue),
        .finish (alu1_finish)
    );

    // three-cycle multiplier, finishes behind the alus
    exec_pipe #(.latency(3)) mdu_inst (
        .clk    (clk),
        .rst    (rst),
        .flush  (flush),
        .issue  (mdu_issue),
        .finish (mdu_finish)
    );

    commit_stage commit_stage_inst (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .row          (row),
        .row_valid    (row_valid),
        .row_ready    (row_ready),
        .retire_valid (retire_valid),
        .retire_ready (retire_ready),
        .retire_dest  (retire_dest),
        .retire_value (retire_value)
    );

endmodule

`default_nettype wire

// ==== tb/clock_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module clock_gen #(
    parameter int period = 40
) (
    output logic clk
);
    // free-running, starts low
    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// ==== tb/rob_core_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module rob_core_tb;
    import rob_pkg::*;

    localparam int max_rec = 64;

    logic        clk;
    logic        rst;
    logic        flush;
    uop_pair_t   in_pair;
    logic        in_valid;
    logic        in_ready;
    logic        retire_valid;
    logic        retire_ready;
    reg_idx_t    retire_dest;
    word_t       retire_value;

    // records from the test file
    int          n_rec = 0;
    logic        rec_end  [max_rec];
    int          rec_test [max_rec];
    logic        rec_flag [max_rec];
    uop_pair_t   rec_pair [max_rec];
    word_t       rec_exp  [max_rec][2];

    // expected retirements in program order
    rob_slot_t   exp_q[$];
    int          cur_rec = 0;
    int          cur_test = 0;
    int          errors = 0;
    int          test_err_base = 0;
    int          stall_count = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    int          cycles = 0;
    int          cycle_limit = 0;
    logic [31:0] rng = 32'hb3fb_c78c;

    clock_gen #(.period(40)) clock_gen_inst (.clk(clk));

    rob_core_top #(
        .rob_depth (8)
    ) rob_core_top_inst (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .in_pair      (in_pair),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .retire_valid (retire_valid),
        .retire_ready (retire_ready),
        .retire_dest  (retire_dest),
        .retire_value (retire_value)
    );

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // low 16 bits of a op b
    function automatic word_t expected_result(logic [1:0] op, word_t a, word_t b);
        logic [31:0] full;
        case (op)
            2'd0:    full = a + b;
            2'd1:    full = a - b;
            2'd2:    full = a ^ b;
            default: full = a * b;
        endcase
        return full[15:0];
    endfunction

    task automatic load_tests();
        int          fd;
        int          cnt;
        int          line_no;
        string       line;
        logic [31:0] kind;
        logic [31:0] tnum;
        logic [31:0] flag;
        logic [31:0] v [2];
        logic [31:0] o [2];
        logic [31:0] d [2];
        logic [31:0] a [2];
        logic [31:0] b [2];
        logic [31:0] e [2];
        line_no = 0;
        fd = $fopen("tb/rob_core_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open tb/rob_core_tests.txt");
            errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            line_no++;
            if (line.len() == 0 || line.getc(0) == "#") begin
                continue;
            end
            cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                          kind, tnum, flag, v[0], o[0], d[0], a[0], b[0], e[0],
                          v[1], o[1], d[1], a[1], b[1], e[1]);
            // blank line
            if (cnt <= 0) begin
                continue;
            end
            if (n_rec == max_rec || cnt < 3 || (kind == 0 && cnt != 15)) begin
                $display("test file error: line %0d cannot be used", line_no);
                errors++;
                continue;
            end
            rec_end[n_rec]  = kind != 0;
            rec_test[n_rec] = tnum;
            rec_flag[n_rec] = flag[0];
            rec_pair[n_rec] = '0;
            if (kind == 0) begin
                for (int s = 0; s < 2; s++) begin
                    rec_pair[n_rec].slot[s].valid = v[s][0];
                    rec_pair[n_rec].slot[s].op    = rob_op_e'(o[s][1:0]);
                    rec_pair[n_rec].slot[s].dest  = d[s][3:0];
                    rec_pair[n_rec].slot[s].opa   = a[s][15:0];
                    rec_pair[n_rec].slot[s].opb   = b[s][15:0];
                    rec_exp[n_rec][s] = e[s][15:0];
                    // file value must agree with the opcode rule
                    if (v[s][0] &&
                        expected_result(o[s][1:0], a[s][15:0], b[s][15:0]) != e[s][15:0]) begin
                        $display("test file error: line %0d slot %0d expects %h, rule gives %h",
                                 line_no, s, e[s][15:0],
                                 expected_result(o[s][1:0], a[s][15:0], b[s][15:0]));
                        errors++;
                    end
                end
            end
            n_rec++;
        end
        $fclose(fd);
    endtask

    // advance one clock and draw a new retire_ready
    task automatic tick();
        @(posedge clk);
        rng = xorshift32(rng);
        retire_ready <= rng[0];
        flush        <= 1'b0;
    endtask

    // offer a pair and hold it until the dut takes it
    task automatic send_pair(int r);
        tick();
        cur_rec = r;
        in_pair  <= rec_pair[r];
        in_valid <= 1'b1;
        @(negedge clk);
        while (in_ready !== 1'b1) begin
            tick();
            @(negedge clk);
        end
    endtask

    // one-cycle flush with the retire port held off
    task automatic apply_flush();
        tick();
        flush        <= 1'b1;
        in_valid     <= 1'b0;
        retire_ready <= 1'b0;
    endtask

    task automatic close_test(int t);
        if (errors == test_err_base) begin
            pass_count++;
            $display("test %0d: pass", t);
        end else begin
            fail_count++;
            $display("test %0d: failed with %0d errors", t, errors - test_err_base);
        end
        test_err_base = errors;
        stall_count   = 0;
    endtask

    // stop offering pairs and wait for the expected retirements
    task automatic end_test(int r);
        tick();
        in_valid <= 1'b0;
        while (exp_q.size() != 0) begin
            tick();
        end
        @(negedge clk);
        if (retire_valid !== 1'b0) begin
            $display("test %0d: retire_valid still high after the last expected retirement",
                     rec_test[r]);
            errors++;
        end
        if (rec_flag[r] && stall_count == 0) begin
            $display("test %0d: in_ready never dropped under back-pressure", rec_test[r]);
            errors++;
        end
        close_test(rec_test[r]);
    endtask

    // scoreboard sampled mid-cycle where everything is settled
    always @(negedge clk) begin
        rob_slot_t want;
        rob_slot_t got;
        if (!rst) begin
            if (flush) begin
                // accepted but unretired work is cancelled
                exp_q.delete();
            end else begin
                if (in_valid && in_ready) begin
                    for (int s = 0; s < 2; s++) begin
                        if (rec_pair[cur_rec].slot[s].valid) begin
                            want.valid  = 1'b1;
                            want.dest   = rec_pair[cur_rec].slot[s].dest;
                            want.result = rec_exp[cur_rec][s];
                            exp_q.push_back(want);
                        end
                    end
                end
                if (in_valid && !in_ready) begin
                    stall_count++;
                end
                if (retire_valid && retire_ready) begin
                    if (exp_q.size() == 0) begin
                        $display("test %0d: retirement to r%0d with nothing expected",
                                 cur_test, retire_dest);
                        errors++;
                    end else begin
                        got = exp_q.pop_front();
                        if (retire_dest !== got.dest) begin
                            $display("FAIL test %0d retire_dest got %h expected %h",
                                     cur_test, retire_dest, got.dest);
                            errors++;
                        end
                        if (retire_value !== got.result) begin
                            $display("FAIL test %0d retire_value got %h expected %h",
                                     cur_test, retire_value, got.result);
                            errors++;
                        end
                    end
                end
            end
        end
    end

    // run limit from the record count
    always @(posedge clk) begin
        cycles++;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("timeout: the run went past %0d cycles", cycle_limit);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        int waited;
        rst          = 1'b1;
        flush        = 1'b0;
        in_valid     = 1'b0;
        in_pair      = '0;
        retire_ready = 1'b0;
        load_tests();
        test_err_base = errors;
        cycle_limit   = 40 * n_rec + 200;

        // test 0 covers the three reset edges
        repeat (2) @(posedge clk);
        @(negedge clk);
        if (in_ready !== 1'b0 || retire_valid !== 1'b0) begin
            $display("test 0: in_ready or retire_valid high during reset");
            errors++;
        end
        @(posedge clk);
        rst <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (in_ready !== 1'b1 && waited < 4) begin
            @(negedge clk);
            waited++;
        end
        if (in_ready !== 1'b1) begin
            $display("test 0: in_ready did not rise after reset");
            errors++;
        end
        if (retire_valid !== 1'b0) begin
            $display("test 0: retire_valid high right after reset");
            errors++;
        end
        close_test(0);

        for (int r = 0; r < n_rec; r++) begin
            cur_test = rec_test[r];
            if (rec_end[r]) begin
                end_test(r);
            end else begin
                if (rec_flag[r]) begin
                    apply_flush();
                end
                send_pair(r);
            end
        end

        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0 && errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/rob_core_tests.txt ====
# kind test flag v0 op0 dest0 a0 b0 exp0 v1 op1 dest1 a1 b1 exp1 (hex; op 0 add 1 sub 2 xor 3 mul)
# kind 0 pair, flag 1 flushes first; kind 1 ends the test, flag 1 expects input stalls
0 1 0 1 0 1 0010 0020 0030 1 3 2 0003 0004 000c
0 1 0 1 3 3 0100 0100 0000 1 2 4 ffff 00f0 ff0f
0 1 0 1 2 5 1234 00ff 12cb 1 0 6 ffff 0002 0001
0 1 0 1 3 7 1234 0010 2340 1 1 8 0005 0007 fffe
1 1 0
0 2 0 1 3 1 0007 0006 002a 1 3 2 00ff 00ff fe01
0 2 0 0 0 0 0000 0000 0000 1 0 3 0011 0022 0033
0 2 0 1 1 4 0100 0001 00ff 0 0 0 0000 0000 0000
0 2 0 0 0 0 0000 0000 0000 0 0 0 0000 0000 0000
0 2 0 0 0 0 0000 0000 0000 1 3 5 0003 0005 000f
0 2 0 1 3 6 1001 0010 0010 1 3 7 0003 8001 8003
1 2 0
0 3 0 1 0 1 0001 0001 0002 1 3 2 0002 0003 0006
0 3 0 1 1 3 0010 0001 000f 1 2 4 00aa 0055 00ff
0 3 0 1 3 5 0004 0004 0010 1 0 6 0100 0200 0300
0 3 0 1 2 7 ff00 0ff0 f0f0 1 1 8 0000 0001 ffff
0 3 0 1 0 9 7fff 0001 8000 1 3 a 0010 0010 0100
0 3 0 1 1 b 8000 0001 7fff 1 2 c 5555 aaaa ffff
0 3 0 1 3 d 0100 0003 0300 1 0 e 1111 2222 3333
0 3 0 1 2 f 0f0f 00ff 0ff0 1 1 0 0009 0003 0006
0 3 0 1 0 1 abcd 0001 abce 1 3 2 0020 0020 0400
0 3 0 1 1 3 1000 0001 0fff 1 2 4 1234 1234 0000
0 3 0 1 3 5 0011 0011 0121 1 0 6 fffe 0003 0001
0 3 0 1 2 7 00f0 000f 00ff 1 1 8 0064 0032 0032
0 3 0 1 0 9 0400 0400 0800 1 3 a 0007 0007 0031
0 3 0 1 1 b 0003 0005 fffe 1 2 c 8001 0001 8000
0 3 0 1 3 d 0080 0200 0000 1 0 e 00ab 0001 00ac
0 3 0 1 2 f cafe 0000 cafe 1 1 0 0001 0001 0000
1 3 1
0 4 0 1 3 1 0005 0005 0019 1 0 2 0001 0002 0003
0 4 0 1 0 3 0010 0010 0020 1 3 4 0006 0006 0024
0 4 0 1 2 5 0f00 00f0 0ff0 1 1 6 0008 0002 0006
0 4 1 1 0 7 0100 0001 0101 1 3 8 0002 0002 0004
0 4 0 1 1 9 0050 0010 0040 1 2 a 00ff 0f0f 0ff0
1 4 0

// ==== all.f ====
common/rob_pkg.sv
hw/dispatch_stage.sv
rob/reorder_buffer.sv
hw/exec_pipe.sv
hw/commit_stage.sv
hw/rob_core_top.sv
tb/clock_gen.sv
tb/rob_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the rob core testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f all.f --top-module rob_core_tb -o sim_rob_core

# a failing simulator exit stops the script here
out=$(./obj_dir/sim_rob_core)
echo "$out"

# pass only when the pass line is present
echo "$out" | grep -qx "Test OK"
